// File: pd_block_store.sv
// ==============================
// Block register and four-phase
// req/ack output handshake
// ==============================
`timescale 1ns/1ps

module pd_block_store (
	input  logic              clk,
	input  logic              n_rst,
	input  pd_pkg::wr_byte_t  i_wr,
	input  logic              i_blk_done,
	input  logic              i_ack,
	output pd_pkg::blk_out_t  o_blk,
	output logic              o_busy
);
	import pd_pkg::*;

	typedef enum logic [1:0] {HS_IDLE, HS_REQ, HS_WAIT_ACK_LOW} hs_state_t;

	hs_state_t hs_q, hs_d;
	block_t    blk_q;

	always_ff @(posedge clk) begin
		if (i_wr.en)
			blk_q[{i_wr.idx, 3'b000} +: 8] <= i_wr.data;
	end

	always_comb begin
		hs_d = hs_q;
		case (hs_q)
			HS_IDLE:         if (i_blk_done) hs_d = HS_REQ;
			HS_REQ:          if (i_ack) hs_d = HS_WAIT_ACK_LOW;
			HS_WAIT_ACK_LOW: if (!i_ack) hs_d = HS_IDLE;   // Core closes the transfer
			default:         hs_d = HS_IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			hs_q <= HS_IDLE;
		else
			hs_q <= hs_d;
	end

	assign o_blk.req  = (hs_q == HS_REQ);
	assign o_blk.data = blk_q;
	assign o_busy     = (hs_q != HS_IDLE);

	a_data_held: assert property (@(posedge clk) disable iff (!n_rst)
		o_blk.req |=> !o_blk.req || $stable(o_blk.data));

endmodule

// File: pd_byte_counter.sv
// ==============================
// Payload byte counter
// ==============================
`timescale 1ns/1ps
`include "pd_defines.svh"

module pd_byte_counter (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               i_cnt_up,
	input  logic               i_cnt_clr,
	output pd_pkg::byte_idx_t  o_cnt,
	output logic               o_last
);
	import pd_pkg::*;

	byte_idx_t cnt_d;

	assign o_last = (o_cnt == byte_idx_t'(`PD_HALF_BYTES - 1));

	always_comb begin
		cnt_d = o_cnt;
		if (i_cnt_clr)
			cnt_d = '0;
		else if (i_cnt_up)
			cnt_d = o_last ? '0 : o_cnt + byte_idx_t'(1);   // Wrap after a half-block
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			o_cnt <= '0;
		else
			o_cnt <= cnt_d;
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (!n_rst)
		o_cnt <= byte_idx_t'(`PD_HALF_BYTES - 1));

endmodule

// File: pd_controller.sv
// ==============================
// Packet decoding FSM with the
// armed address flag
// ==============================
`timescale 1ns/1ps
`include "pd_defines.svh"

module pd_controller (
	input  logic                clk,
	input  logic                n_rst,
	input  pd_pkg::rx_byte_t    i_rx,
	input  logic                i_last,
	input  pd_pkg::byte_idx_t   i_cnt,
	input  logic                i_busy,
	output pd_pkg::pd_status_t  o_status,
	output logic                o_cnt_up,
	output logic                o_cnt_clr,
	output pd_pkg::wr_byte_t    o_wr,
	output logic                o_blk_done
);
	import pd_pkg::*;

	pd_state_t state_q, state_d;
	pd_state_t drain_to;
	logic      armed_q, armed_d;
	logic      tok_out_q, tok_out_d;   // Token in flight is OUT
	logic      half1_q, half1_d;       // First half of the block written
	logic      half2_q, half2_d;       // Current packet is DATA1
	logic      pid_ok;
	byte_t     data_q;
	dev_addr_t addr;

	assign pid_ok    = (i_rx.data[3:0] == ~i_rx.data[7:4]);
	assign drain_to  = i_rx.eop ? IDLE : DRAIN;
	assign addr      = data_q[7:1];
	assign o_cnt_clr = (state_q == READ_PID);   // Every packet starts at zero

	always_ff @(posedge clk) begin
		if (i_rx.valid)
			data_q <= i_rx.data;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state_q   <= IDLE;
			armed_q   <= 1'b0;
			tok_out_q <= 1'b0;
			half1_q   <= 1'b0;
			half2_q   <= 1'b0;
		end else begin
			state_q   <= state_d;
			armed_q   <= armed_d;
			tok_out_q <= tok_out_d;
			half1_q   <= half1_d;
			half2_q   <= half2_d;
		end
	end

	always_comb begin
		state_d    = state_q;
		armed_d    = armed_q;
		tok_out_d  = tok_out_q;
		half1_d    = half1_q;
		half2_d    = half2_q;
		o_status   = '0;
		o_cnt_up   = 1'b0;
		o_blk_done = 1'b0;
		o_wr.en    = 1'b0;
		o_wr.data  = data_q;
		o_wr.idx   = half2_q ? i_cnt + byte_idx_t'(`PD_HALF_BYTES) : i_cnt;
		case (state_q)
			IDLE: begin
				if (i_rx.valid)
					state_d = pid_ok ? READ_PID : ERROR;
			end
			READ_PID: begin
				tok_out_d = (data_q == `PD_PID_OUT);
				half2_d   = (data_q == `PD_PID_DATA1);
				case (data_q)
					`PD_PID_IN, `PD_PID_OUT: state_d = WAIT_ADDR;
					`PD_PID_DATA0: state_d = armed_q ? WAIT_CMD : drain_to;
					`PD_PID_DATA1: state_d = (armed_q && half1_q) ? HALF_WAIT : drain_to;
					default: state_d = drain_to;
				endcase
			end
			WAIT_ADDR: begin
				if (i_rx.valid)
					state_d = CHECK_ADDR;
				else if (i_rx.eop)
					state_d = IDLE;
			end
			CHECK_ADDR: begin
				if (addr != `PD_DEV_ADDR) begin
					state_d = drain_to;
				end else if (tok_out_q) begin
					armed_d = 1'b1;
					state_d = i_rx.eop ? IDLE : OUT_EOP_WAIT;
				end else begin
					state_d = i_rx.eop ? HOST_READY : IN_EOP_WAIT;
				end
			end
			IN_EOP_WAIT: begin
				if (i_rx.eop)
					state_d = HOST_READY;
			end
			HOST_READY: begin
				o_status.host_ready = 1'b1;
				state_d = IDLE;
			end
			OUT_EOP_WAIT: begin
				if (i_rx.eop)
					state_d = IDLE;
			end
			WAIT_CMD: begin
				if (i_rx.valid)
					state_d = CHECK_CMD;
				else if (i_rx.eop)
					state_d = IDLE;
			end
			CHECK_CMD: begin
				case (data_q)
					`PD_CMD_INTERRUPT: begin
						o_status.quit_hash = 1'b1;
						armed_d = 1'b0;
						half1_d = 1'b0;
						state_d = drain_to;
					end
					`PD_CMD_HASH: begin
						half1_d = 1'b0;
						state_d = i_busy ? ERROR : HALF_WAIT;   // Previous block still pending
					end
					default: state_d = ERROR;
				endcase
			end
			HALF_WAIT: begin
				if (i_rx.valid)
					state_d = HALF_WRITE;
				else if (i_rx.eop)
					state_d = IDLE;
			end
			HALF_WRITE: begin
				o_wr.en  = 1'b1;
				o_cnt_up = 1'b1;
				if (!i_last) begin
					state_d = i_rx.eop ? IDLE : HALF_WAIT;
				end else if (half2_q) begin
					o_blk_done = 1'b1;
					state_d    = BLOCK_DONE;
				end else begin
					half1_d = 1'b1;
					state_d = drain_to;
				end
			end
			BLOCK_DONE: begin
				o_status.new_block = 1'b1;
				armed_d = 1'b0;
				half1_d = 1'b0;
				state_d = drain_to;
			end
			ERROR: begin
				o_status.p_error = 1'b1;
				state_d = drain_to;
			end
			DRAIN: begin
				if (i_rx.eop)
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	// Store must be idle for any payload write
	a_no_wr_busy: assert property (@(posedge clk) disable iff (!n_rst)
		o_wr.en |-> !i_busy);

	a_one_status: assert property (@(posedge clk) disable iff (!n_rst)
		$onehot0(o_status));

endmodule

// File: pd_defines.svh
// ==============================
// PID codes, device address,
// command codes and block sizes
// ==============================
`ifndef PD_DEFINES_SVH
`define PD_DEFINES_SVH

// Low nibble is the PID, high nibble its complement
`define PD_PID_IN        8'b0110_1001
`define PD_PID_OUT       8'b1110_0001
`define PD_PID_DATA0     8'b1100_0011
`define PD_PID_DATA1     8'b0100_1011

`define PD_DEV_ADDR      7'b1100001   // Bits 7:1 of the address byte

`define PD_CMD_INTERRUPT 8'h00
`define PD_CMD_HASH      8'h01

`define PD_HALF_BYTES    16
`define PD_BLOCK_BYTES   32

`endif

// File: pd_pkg.sv
// ==============================
// Packet decoder types, states
// and bundled signals
// ==============================
`include "pd_defines.svh"

package pd_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [6:0] dev_addr_t;
	typedef logic [$clog2(`PD_BLOCK_BYTES)-1:0] byte_idx_t;
	typedef logic [`PD_BLOCK_BYTES*8-1:0] block_t;   // Byte 0 in the low bits

	typedef enum logic [3:0] {
		IDLE, READ_PID, WAIT_ADDR, CHECK_ADDR, IN_EOP_WAIT, HOST_READY,
		OUT_EOP_WAIT, WAIT_CMD, CHECK_CMD, HALF_WAIT, HALF_WRITE,
		BLOCK_DONE, ERROR, DRAIN
	} pd_state_t;

	typedef struct packed {
		logic  valid;
		logic  eop;    // Own strobe, valid is low with it
		byte_t data;
	} rx_byte_t;

	typedef struct packed {
		logic host_ready;
		logic p_error;
		logic quit_hash;
		logic new_block;
	} pd_status_t;

	typedef struct packed {
		logic      en;
		byte_idx_t idx;
		byte_t     data;
	} wr_byte_t;

	typedef struct packed {
		logic   req;
		block_t data;
	} blk_out_t;

endpackage

// File: pd_top.sv
// ==============================
// Packet decoder top level
// ==============================
`timescale 1ns/1ps

module pd_top (
	input  logic                clk,
	input  logic                n_rst,
	input  pd_pkg::rx_byte_t    i_rx,
	input  logic                i_ack,
	output pd_pkg::pd_status_t  o_status,
	output pd_pkg::blk_out_t    o_blk
);
	import pd_pkg::*;

	logic      cnt_up;
	logic      cnt_clr;
	logic      last;
	byte_idx_t cnt;
	wr_byte_t  wr;
	logic      blk_done;
	logic      busy;

	pd_controller u_controller (
		.clk        (clk),
		.n_rst      (n_rst),
		.i_rx       (i_rx),
		.i_last     (last),
		.i_cnt      (cnt),
		.i_busy     (busy),
		.o_status   (o_status),
		.o_cnt_up   (cnt_up),
		.o_cnt_clr  (cnt_clr),
		.o_wr       (wr),
		.o_blk_done (blk_done)
	);

	pd_byte_counter u_byte_counter (
		.clk       (clk),
		.n_rst     (n_rst),
		.i_cnt_up  (cnt_up),
		.i_cnt_clr (cnt_clr),
		.o_cnt     (cnt),
		.o_last    (last)
	);

	pd_block_store u_block_store (
		.clk        (clk),
		.n_rst      (n_rst),
		.i_wr       (wr),
		.i_blk_done (blk_done),
		.i_ack      (i_ack),
		.o_blk      (o_blk),
		.o_busy     (busy)
	);

endmodule

// File: project.f
+incdir+.
pd_pkg.sv
pd_controller.sv
pd_byte_counter.sv
pd_block_store.sv
pd_top.sv
tb_pd_checker.sv
tb_pd_top.sv

// File: run_sim.sh
#!/bin/bash
# Builds the packet decoder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_pd_top \
	--Mdir obj_dir -o tb_pd_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pd_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "sim passed" "$SIM_LOG"; then
	echo "No result line found in $SIM_LOG"
	exit 1
fi
exit 0

// File: tb_pd_checker.sv
// ==============================
// Status pulse counting, block
// ack and per-test report
// ==============================
`timescale 1ns/1ps

module tb_pd_checker (
	input  logic                clk,
	input  logic                n_rst,
	input  pd_pkg::pd_status_t  i_status,
	input  pd_pkg::blk_out_t    i_blk,
	input  logic                i_hold,
	input  pd_pkg::block_t      i_exp_blk,
	input  logic [3:0][3:0]     i_exp_pulses,
	input  logic                i_exp_hs,
	input  logic                i_test_end,
	input  int                  i_test_idx,
	input  logic                i_done,
	output logic                o_ack,
	output int                  o_fail_cnt,
	output int                  o_test_cnt
);
	import pd_pkg::*;

	logic            ack = 1'b0;
	int              pulses [4] = '{default: 0};
	int              hs_cnt = 0;
	int              req_cycles = 0;
	int              fails = 0;
	int              tests = 0;
	logic            req_seen = 1'b0;
	logic            test_bad = 1'b0;
	logic            reported = 1'b0;

	logic            hold_q = 1'b0;
	block_t          exp_blk_q = '0;
	logic [3:0][3:0] exp_pulses_q = '0;
	logic            exp_hs_q = 1'b0;
	logic            end_q = 1'b0;
	int              idx_q = 0;
	logic            done_q = 1'b0;

	assign o_ack      = ack;
	assign o_fail_cnt = fails;
	assign o_test_cnt = tests;

	function automatic string pulse_name(input int k);
		case (k)
			3:       return "o_status.host_ready";
			2:       return "o_status.p_error";
			1:       return "o_status.quit_hash";
			default: return "o_status.new_block";
		endcase
	endfunction

	task automatic check_block(input string when);
		if (i_blk.data !== exp_blk_q) begin
			$display("ERROR t=%0t o_blk.data %s: expected %h, actual %h",
				$time, when, exp_blk_q, i_blk.data);
			test_bad = 1'b1;
		end
	endtask

	task automatic report_test();
		for (int k = 3; k >= 0; k--) begin
			if (pulses[k] != int'(exp_pulses_q[k])) begin
				$display("ERROR t=%0t %s count: expected %0d, actual %0d",
					$time, pulse_name(k), exp_pulses_q[k], pulses[k]);
				test_bad = 1'b1;
			end
			pulses[k] = 0;
		end
		if (exp_hs_q && hs_cnt == 0) begin
			$display("test %0d: block handshake with the hash core never completed", idx_q);
			test_bad = 1'b1;
		end else if (!exp_hs_q && hs_cnt != 0) begin
			$display("test %0d: a block handshake completed where none was due", idx_q);
			test_bad = 1'b1;
		end
		$display("test %0d %s", idx_q, test_bad ? "FAILED" : "ok");
		tests++;
		if (test_bad)
			fails++;
		test_bad = 1'b0;
		hs_cnt   = 0;
	endtask

	always @(posedge clk) begin
		hold_q       <= i_hold;
		exp_blk_q    <= i_exp_blk;
		exp_pulses_q <= i_exp_pulses;
		exp_hs_q     <= i_exp_hs;
		end_q        <= i_test_end;
		idx_q        <= i_test_idx;
		done_q       <= i_done;
	end

	// DUT outputs move on the rising edge, read them on the falling one
	always @(negedge clk) begin
		if (!n_rst) begin
			ack        = 1'b0;
			req_cycles = 0;
		end else begin
			for (int k = 0; k < 4; k++)
				if (i_status[k])
					pulses[k]++;
			if (i_blk.req && !req_seen)
				check_block("at req rise");
			req_seen = i_blk.req;
			if (i_blk.req && !ack && !hold_q) begin
				req_cycles++;
				if (req_cycles == 2) begin
					ack = 1'b1;
					check_block("at ack rise");   // Pending data unchanged
				end
			end else if (ack && !i_blk.req) begin
				ack        = 1'b0;
				req_cycles = 0;
				hs_cnt++;
			end
			if (end_q)
				report_test();
			if (done_q && !reported) begin
				$display("tests run %0d, passed %0d, failed %0d", tests, tests - fails, fails);
				reported = 1'b1;
			end
		end
	end

endmodule

// File: tb_pd_top.sv
// ==============================
// Packet decoder testbench top:
// clock, stimulus table, watchdog
// ==============================
`timescale 1ns/1ps
`include "pd_defines.svh"

module tb_pd_top;
	import pd_pkg::*;

	localparam int          N_TESTS  = 21;
	localparam byte_t       ADDR_OK  = {`PD_DEV_ADDR, 1'b0};
	localparam byte_t       ADDR_BAD = 8'h24;
	// Expected pulse counts, one nibble per pd_status_t bit
	localparam logic [15:0] NONE = 16'h0000;
	localparam logic [15:0] HR   = 16'h1000;
	localparam logic [15:0] PE   = 16'h0100;
	localparam logic [15:0] QH   = 16'h0010;
	localparam logic [15:0] NB   = 16'h0001;

	logic       clk = 1'b0;
	logic       n_rst = 1'b0;
	rx_byte_t   rx = '0;
	logic       ack;
	pd_status_t status;
	blk_out_t   blk;

	byte_t           tab_bytes [N_TESTS][18];
	int              tab_len [N_TESTS];
	logic [3:0][3:0] tab_pulses [N_TESTS];
	logic            tab_hs [N_TESTS];     // Handshake finishes in this test
	logic            tab_hold [N_TESTS];   // Core withholds ack
	block_t          tab_blk [N_TESTS];
	int              n_entries = 0;

	byte_t           pkt [18];
	block_t          cur_blk = '0;
	integer          seed = 32'h929cef61;

	logic            hold = 1'b0;
	block_t          exp_blk = '0;
	logic [3:0][3:0] exp_pulses = '0;
	logic            exp_hs = 1'b0;
	logic            test_end = 1'b0;
	int              test_idx = 0;
	logic            done = 1'b0;
	int              fail_cnt;
	int              test_cnt;

	task automatic push_entry(input int len, input logic [15:0] pulses, input logic hs,
			input logic hld);
		for (int i = 0; i < 18; i++)
			tab_bytes[n_entries][i] = pkt[i];
		tab_len[n_entries]    = len;
		tab_pulses[n_entries] = pulses;
		tab_hs[n_entries]     = hs;
		tab_hold[n_entries]   = hld;
		tab_blk[n_entries]    = cur_blk;
		n_entries++;
	endtask

	task automatic random_payload(input int pos, input int base, input logic keep);
		byte_t b;
		for (int i = 0; i < `PD_HALF_BYTES; i++) begin
			b = byte_t'($random(seed));
			pkt[pos + i] = b;
			if (keep)
				cur_blk[(base + i) * 8 +: 8] = b;   // Byte 0 in the low bits
		end
	endtask

	task automatic set_token(input byte_t pid, input byte_t addr);
		pkt[0] = pid;
		pkt[1] = addr;
	endtask

	task automatic data0_packet(input byte_t cmd, input logic keep);
		pkt[0] = `PD_PID_DATA0;
		pkt[1] = cmd;
		random_payload(2, 0, keep);
	endtask

	task automatic data1_packet(input logic keep);
		pkt[0] = `PD_PID_DATA1;
		random_payload(1, `PD_HALF_BYTES, keep);
	endtask

	task automatic build_table();
		set_token(`PD_PID_IN, ADDR_OK);
		push_entry(2, HR, 1'b0, 1'b0);
		set_token(`PD_PID_IN, ADDR_BAD);
		push_entry(2, NONE, 1'b0, 1'b0);
		pkt[0] = 8'h55;                      // Nibbles not complementary
		push_entry(1, PE, 1'b0, 1'b0);
		set_token(`PD_PID_IN, ADDR_OK);
		push_entry(2, HR, 1'b0, 1'b0);
		data0_packet(`PD_CMD_HASH, 1'b0);   // Not armed yet
		push_entry(18, NONE, 1'b0, 1'b0);
		set_token(`PD_PID_OUT, ADDR_OK);
		push_entry(2, NONE, 1'b0, 1'b0);
		data0_packet(8'h5a, 1'b0);
		push_entry(2, PE, 1'b0, 1'b0);
		data0_packet(`PD_CMD_HASH, 1'b1);
		push_entry(18, NONE, 1'b0, 1'b0);
		data1_packet(1'b1);
		push_entry(17, NB, 1'b1, 1'b0);
		// Interrupt after a first half, DATA1 must then be dropped
		set_token(`PD_PID_OUT, ADDR_OK);
		push_entry(2, NONE, 1'b0, 1'b0);
		data0_packet(`PD_CMD_HASH, 1'b0);
		push_entry(18, NONE, 1'b0, 1'b0);
		data0_packet(`PD_CMD_INTERRUPT, 1'b0);
		push_entry(2, QH, 1'b0, 1'b0);
		data1_packet(1'b0);
		push_entry(17, NONE, 1'b0, 1'b0);
		// Disarmed, so a full HASH block without a new OUT gives nothing
		data0_packet(`PD_CMD_HASH, 1'b0);
		push_entry(18, NONE, 1'b0, 1'b0);
		data1_packet(1'b0);
		push_entry(17, NONE, 1'b0, 1'b0);
		// Back-pressure
		set_token(`PD_PID_OUT, ADDR_OK);
		push_entry(2, NONE, 1'b0, 1'b0);
		data0_packet(`PD_CMD_HASH, 1'b1);
		push_entry(18, NONE, 1'b0, 1'b0);
		data1_packet(1'b1);
		push_entry(17, NB, 1'b0, 1'b1);
		set_token(`PD_PID_OUT, ADDR_OK);
		push_entry(2, NONE, 1'b0, 1'b1);
		data0_packet(`PD_CMD_HASH, 1'b0);
		push_entry(18, PE, 1'b0, 1'b1);
		set_token(`PD_PID_IN, ADDR_OK);      // Ack released here
		push_entry(2, HR, 1'b1, 1'b0);
	endtask

	initial begin
		forever #50 clk = ~clk;
	end

	initial begin
		build_table();
		repeat (2) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		for (int t = 0; t < n_entries; t++) begin
			test_idx   = t;
			exp_pulses = tab_pulses[t];
			exp_hs     = tab_hs[t];
			exp_blk    = tab_blk[t];
			hold       = tab_hold[t];
			for (int i = 0; i < tab_len[t]; i++) begin
				rx.valid = 1'b1;
				rx.data  = tab_bytes[t][i];
				@(negedge clk);
				rx = '0;
				@(negedge clk);
			end
			rx.eop = 1'b1;
			@(negedge clk);
			rx = '0;
			repeat (4) @(negedge clk);
			test_end = 1'b1;
			@(negedge clk);
			test_end = 1'b0;
		end
		done = 1'b1;
		repeat (2) @(negedge clk);
		if (test_cnt != n_entries)
			$display("only %0d of %0d tests were reported", test_cnt, n_entries);
		if (fail_cnt == 0 && test_cnt == n_entries)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Longest packet needs well under 60 cycles
	initial begin
		repeat (N_TESTS * 60) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", N_TESTS * 60);
		$display("sim failed");
		$finish;
	end

	pd_top DUT (
		.clk      (clk),
		.n_rst    (n_rst),
		.i_rx     (rx),
		.i_ack    (ack),
		.o_status (status),
		.o_blk    (blk)
	);

	tb_pd_checker u_checker (
		.clk          (clk),
		.n_rst        (n_rst),
		.i_status     (status),
		.i_blk        (blk),
		.i_hold       (hold),
		.i_exp_blk    (exp_blk),
		.i_exp_pulses (exp_pulses),
		.i_exp_hs     (exp_hs),
		.i_test_end   (test_end),
		.i_test_idx   (test_idx),
		.i_done       (done),
		.o_ack        (ack),
		.o_fail_cnt   (fail_cnt),
		.o_test_cnt   (test_cnt)
	);

endmodule
